// File: src/loopPkg.sv
package loopPkg;

    localparam int NUM_CHANNELS = 4;
    localparam logic [15:0] LOCK_MAX = 16'hFFFF;  // Lock counter saturates here

    // Register offsets within a channel, addr[7:0]
    localparam logic [7:0] LF_CONTROL      = 8'h00;
    localparam logic [7:0] LF_LEAD_LAG     = 8'h04;
    localparam logic [7:0] LF_LIMIT        = 8'h08;
    localparam logic [7:0] LF_LOOPDATA     = 8'h0C;
    localparam logic [7:0] LF_LOCKDETECTOR = 8'h10;
    localparam logic [7:0] LF_INTEGRATOR   = 8'h14;  // Read only

    // One host request, active when byteWrite is nonzero or read is set
    typedef struct packed {
        logic [11:0] addr;       // [11:8] channel, [7:0] offset
        logic [31:0] dataIn;
        logic [3:0]  byteWrite;  // One strobe per byte lane
        logic        read;
    } busReq_t;

    typedef struct packed {
        logic        zeroError;
        logic        invertError;
        logic        holdAccum;
        logic        clearAccum;
        logic [4:0]  leadExp;
        logic [7:0]  leadMan;
        logic [4:0]  lagExp;
        logic [7:0]  lagMan;
        logic [31:0] limit;       // Integrator clamp, kept below 2^31
        logic [31:0] loopData;    // Nominal frequency offset
        logic [15:0] lockCount;
        logic [7:0]  syncThreshold;
    } loopCfg_t;

    typedef struct packed {
        logic               valid;
        logic signed [15:0] value;
    } errSample_t;

    typedef struct packed {
        logic [31:0]        loopOut;
        logic               outValid;
        logic signed [31:0] accum;
        logic               locked;
    } chanStatus_t;

endpackage

// File: src/busDecoder.sv
module busDecoder (
    input  logic                                  clk,
    input  logic                                  reset,
    input  loopPkg::busReq_t                      request,
    output logic [31:0]                           writeData,
    output logic [7:0]                            regOffset,
    output logic [loopPkg::NUM_CHANNELS-1:0][3:0] byteWrite,
    output logic [loopPkg::NUM_CHANNELS-1:0]      readSelect,
    output logic                                  readActive
);
    import loopPkg::*;

    logic [3:0] channel;

    assign channel = request.addr[11:8];

    always_ff @(posedge clk) begin
        writeData <= request.dataIn;
        regOffset <= request.addr[7:0];
    end

    // Channels 4..15 match no slot, so their strobes and selects stay low
    always_ff @(posedge clk) begin
        if (reset) begin
            byteWrite  <= '0;
            readSelect <= '0;
            readActive <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                byteWrite[i]  <= (int'(channel) == i) ? request.byteWrite : 4'h0;
                readSelect[i] <= (int'(channel) == i) && request.read;
            end
            readActive <= request.read;  // Out-of-range reads still answer
        end
    end

    // Host never mixes a write and a read in one request
    assert property (@(posedge clk) disable iff (reset)
        !((|request.byteWrite) && request.read))
        else $error("busDecoder: write and read in the same request");

endmodule

// File: src/loopRegs.sv
module loopRegs (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        writeData,
    input  logic [7:0]         regOffset,
    input  logic [3:0]         byteWrite,
    input  logic               readSelect,
    input  logic signed [31:0] accum,
    output loopPkg::loopCfg_t  cfg,
    output logic [31:0]        readback
);
    import loopPkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else begin
            if (byteWrite[0]) begin
                case (regOffset)
                    LF_CONTROL: begin
                        cfg.zeroError   <= writeData[0];
                        cfg.invertError <= writeData[1];
                        cfg.holdAccum   <= writeData[2];
                        cfg.clearAccum  <= writeData[3];
                    end
                    LF_LEAD_LAG:     cfg.lagExp         <= writeData[4:0];
                    LF_LIMIT:        cfg.limit[7:0]     <= writeData[7:0];
                    LF_LOOPDATA:     cfg.loopData[7:0]  <= writeData[7:0];
                    LF_LOCKDETECTOR: cfg.lockCount[7:0] <= writeData[7:0];
                    default: ;
                endcase
            end
            if (byteWrite[1]) begin
                case (regOffset)
                    LF_LEAD_LAG:     cfg.lagMan          <= writeData[15:8];
                    LF_LIMIT:        cfg.limit[15:8]     <= writeData[15:8];
                    LF_LOOPDATA:     cfg.loopData[15:8]  <= writeData[15:8];
                    LF_LOCKDETECTOR: cfg.lockCount[15:8] <= writeData[15:8];
                    default: ;
                endcase
            end
            if (byteWrite[2]) begin
                case (regOffset)
                    LF_LEAD_LAG:     cfg.leadExp         <= writeData[20:16];
                    LF_LIMIT:        cfg.limit[23:16]    <= writeData[23:16];
                    LF_LOOPDATA:     cfg.loopData[23:16] <= writeData[23:16];
                    LF_LOCKDETECTOR: cfg.syncThreshold   <= writeData[23:16];
                    default: ;
                endcase
            end
            if (byteWrite[3]) begin
                case (regOffset)
                    LF_LEAD_LAG: cfg.leadMan         <= writeData[31:24];
                    LF_LIMIT:    cfg.limit[31:24]    <= writeData[31:24];
                    LF_LOOPDATA: cfg.loopData[31:24] <= writeData[31:24];
                    default: ;  // Top byte of the lock detector is unused
                endcase
            end
        end
    end

    always_comb begin
        readback = '0;
        if (readSelect) begin
            case (regOffset)
                LF_CONTROL: begin
                    readback = {28'h0, cfg.clearAccum, cfg.holdAccum,
                                cfg.invertError, cfg.zeroError};
                end
                LF_LEAD_LAG: begin
                    readback = {cfg.leadMan, 3'b000, cfg.leadExp,
                                cfg.lagMan, 3'b000, cfg.lagExp};
                end
                LF_LIMIT:        readback = cfg.limit;
                LF_LOOPDATA:     readback = cfg.loopData;
                LF_LOCKDETECTOR: readback = {8'h00, cfg.syncThreshold, cfg.lockCount};
                LF_INTEGRATOR:   readback = accum;
                default:         readback = '0;
            endcase
        end
    end

    // The decoder's strobes come out of reset cleared
    assert property (@(posedge clk) reset |=> (byteWrite == 4'h0))
        else $error("loopRegs: byte write right after reset");

endmodule

// File: src/loopFilter.sv
module loopFilter (
    input  logic                 clk,
    input  logic                 reset,
    input  loopPkg::loopCfg_t    cfg,
    input  loopPkg::errSample_t  error,
    output loopPkg::chanStatus_t status
);
    import loopPkg::*;

    logic signed [16:0] effError;
    logic        [16:0] errMag;
    logic signed [25:0] leadProd;
    logic signed [25:0] lagProd;
    logic signed [31:0] propTerm;
    logic signed [31:0] intStep;
    logic signed [32:0] accumSum;
    logic signed [32:0] limitPos;
    logic signed [32:0] limitNeg;
    logic signed [31:0] accumNext;
    logic        [15:0] lockNext;
    logic signed [31:0] accum;
    logic        [15:0] lockCounter;
    logic        [31:0] loopOut;
    logic               outValid;
    logic               locked;
    logic        [32:0] accumMag;

    always_comb begin
        effError = 17'(error.value);  // Sign extend so -32768 can be negated
        if (cfg.zeroError) begin
            effError = '0;
        end else if (cfg.invertError) begin
            effError = -effError;
        end
        errMag = effError[16] ? -effError : effError;

        // Mantissa is unsigned, so give it a zero sign bit
        leadProd = effError * $signed({1'b0, cfg.leadMan});
        lagProd  = effError * $signed({1'b0, cfg.lagMan});
        propTerm = 32'(leadProd) <<< cfg.leadExp;
        intStep  = 32'(lagProd) <<< cfg.lagExp;

        limitPos = $signed({1'b0, cfg.limit});
        limitNeg = -limitPos;
        accumSum = 33'(accum) + 33'(intStep);

        if (cfg.clearAccum) accumNext = '0;
        else if (cfg.holdAccum) accumNext = accum;
        else if (accumSum > limitPos) accumNext = limitPos[31:0];
        else if (accumSum < limitNeg) accumNext = limitNeg[31:0];
        else accumNext = accumSum[31:0];

        if (errMag < {9'h000, cfg.syncThreshold}) begin
            lockNext = (lockCounter == LOCK_MAX) ? lockCounter : lockCounter + 16'd1;
        end else begin
            lockNext = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            accum       <= '0;
            lockCounter <= '0;
            outValid    <= 1'b0;
        end else begin
            outValid <= error.valid;
            if (error.valid) begin
                accum       <= accumNext;
                lockCounter <= lockNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (error.valid) begin
            loopOut <= cfg.loopData + propTerm + accumNext;  // Wraps mod 2^32
        end
    end

    assign locked = (lockCounter >= cfg.lockCount) && (cfg.lockCount != 16'h0000);

    assign status = '{loopOut: loopOut, outValid: outValid, accum: accum, locked: locked};

    assign accumMag = accum[31] ? -{1'b1, accum} : {1'b0, accum};

    // After an integrating update the accumulator sits inside the limit in force
    assert property (@(posedge clk) disable iff (reset)
        (error.valid && !cfg.holdAccum && !cfg.limit[31])
            |=> (accumMag <= {1'b0, $past(cfg.limit)}))
        else $error("loopFilter: accumulator beyond limit");

endmodule

// File: src/readMux.sv
module readMux (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [loopPkg::NUM_CHANNELS-1:0][31:0] readback,
    input  logic [loopPkg::NUM_CHANNELS-1:0]       readSelect,
    input  logic                                   readActive,
    input  logic [loopPkg::NUM_CHANNELS-1:0]       lockedIn,
    output logic [31:0]                            readData,
    output logic                                   readValid,
    output logic [loopPkg::NUM_CHANNELS-1:0]       lockFlags
);
    import loopPkg::*;

    logic [31:0] merged;

    always_comb begin
        merged = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (readSelect[i]) merged = merged | readback[i];
        end
    end

    always_ff @(posedge clk) begin
        readData <= merged;  // Zero when no channel is selected
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            readValid <= 1'b0;
            lockFlags <= '0;
        end else begin
            readValid <= readActive;
            lockFlags <= lockedIn;
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(readSelect))
        else $error("readMux: more than one channel selected");

endmodule

// File: src/loopTop.sv
module loopTop (
    input  logic                                         clk,
    input  logic                                         reset,
    input  loopPkg::busReq_t                             request,
    input  loopPkg::errSample_t  [loopPkg::NUM_CHANNELS-1:0] errors,
    output loopPkg::chanStatus_t [loopPkg::NUM_CHANNELS-1:0] status,
    output logic [31:0]                                  readData,
    output logic                                         readValid,
    output logic [loopPkg::NUM_CHANNELS-1:0]             lockFlags
);
    import loopPkg::*;

    logic [31:0]                        writeData;
    logic [7:0]                         regOffset;
    logic [NUM_CHANNELS-1:0][3:0]       chanWrite;
    logic [NUM_CHANNELS-1:0]            readSelect;
    logic                               readActive;
    logic [NUM_CHANNELS-1:0][31:0]      readback;
    logic [NUM_CHANNELS-1:0]            lockedIn;

    busDecoder decoder (
        .clk        (clk),
        .reset      (reset),
        .request    (request),
        .writeData  (writeData),
        .regOffset  (regOffset),
        .byteWrite  (chanWrite),
        .readSelect (readSelect),
        .readActive (readActive)
    );

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : gChan
        loopCfg_t cfg;

        loopRegs regs (
            .clk        (clk),
            .reset      (reset),
            .writeData  (writeData),
            .regOffset  (regOffset),
            .byteWrite  (chanWrite[ch]),
            .readSelect (readSelect[ch]),
            .accum      (status[ch].accum),  // LF_INTEGRATOR readback
            .cfg        (cfg),
            .readback   (readback[ch])
        );

        loopFilter filter (
            .clk    (clk),
            .reset  (reset),
            .cfg    (cfg),
            .error  (errors[ch]),
            .status (status[ch])
        );

        assign lockedIn[ch] = status[ch].locked;
    end

    readMux mux (
        .clk        (clk),
        .reset      (reset),
        .readback   (readback),
        .readSelect (readSelect),
        .readActive (readActive),
        .lockedIn   (lockedIn),
        .readData   (readData),
        .readValid  (readValid),
        .lockFlags  (lockFlags)
    );

endmodule

// File: tb/loopChecker.sv
module loopChecker (
    input  logic                                             clk,
    input  logic                                             reset,
    input  loopPkg::busReq_t                                 request,
    input  loopPkg::errSample_t  [loopPkg::NUM_CHANNELS-1:0] errors,
    input  loopPkg::chanStatus_t [loopPkg::NUM_CHANNELS-1:0] status,
    input  logic [31:0]                                      readData,
    input  logic                                             readValid,
    input  logic [loopPkg::NUM_CHANNELS-1:0]                 lockFlags,
    output int                                               errorCount,
    output int                                               checkCount
);
    import loopPkg::*;

    // Register images, stored with unused bits cleared
    logic [31:0] ctrlReg [NUM_CHANNELS];
    logic [31:0] leadLagReg [NUM_CHANNELS];
    logic [31:0] limitReg [NUM_CHANNELS];
    logic [31:0] loopDataReg [NUM_CHANNELS];
    logic [31:0] lockDetReg [NUM_CHANNELS];
    int          accumModel [NUM_CHANNELS];
    logic [15:0] lockCnt [NUM_CHANNELS];
    busReq_t     pending;  // Request as held by the decoder stage
    logic        armed;

    logic [31:0] expLoopOut [NUM_CHANNELS];
    logic        expOutValid [NUM_CHANNELS];
    logic        expLocked [NUM_CHANNELS];
    logic [31:0] expReadData;
    logic        expReadValid;
    logic [NUM_CHANNELS-1:0] expLockFlags;

    function automatic logic [31:0] laneMerge(logic [31:0] old, logic [31:0] data,
                                               logic [3:0] lanes, logic [31:0] used);
        logic [31:0] mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}} & used;
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic logic [31:0] modelRead(int ch, logic [7:0] off);
        if (ch >= NUM_CHANNELS) return 32'h0;
        case (off)
            LF_CONTROL:      return ctrlReg[ch];
            LF_LEAD_LAG:     return leadLagReg[ch];
            LF_LIMIT:        return limitReg[ch];
            LF_LOOPDATA:     return loopDataReg[ch];
            LF_LOCKDETECTOR: return lockDetReg[ch];
            LF_INTEGRATOR:   return accumModel[ch];
            default:         return 32'h0;
        endcase
    endfunction

    function automatic logic lockOf(int ch);
        return (lockCnt[ch] >= lockDetReg[ch][15:0]) && (lockDetReg[ch][15:0] != 0);
    endfunction

    // Gain of mantissa and exponent, wrapped to 32 bits signed
    function automatic int scaled(int e, logic [7:0] man, logic [4:0] expo);
        longint p;
        int r;
        p = longint'(e) * longint'(man);
        p = p <<< expo;
        r = p[31:0];
        return r;
    endfunction

    task automatic compareWord(string what, int ch, logic [31:0] got, logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %0t: ch%0d %s got %h expected %h", $time, ch, what, got, exp);
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        armed = 1'b0;
    end

    always @(posedge clk) begin
        int ch;
        int e;
        int prop;
        int step;
        longint sum;
        longint lim;
        int mag;
        if (reset) begin
            armed = 1'b0;
            pending = '0;
            expReadValid = 1'b0;
            expLockFlags = '0;
            for (ch = 0; ch < NUM_CHANNELS; ch++) begin
                ctrlReg[ch] = 0;
                leadLagReg[ch] = 0;
                limitReg[ch] = 0;
                loopDataReg[ch] = 0;
                lockDetReg[ch] = 0;
                accumModel[ch] = 0;
                lockCnt[ch] = 0;
                expOutValid[ch] = 1'b0;
                expLocked[ch] = 1'b0;
            end
        end else begin
            armed = 1'b1;
            for (ch = 0; ch < NUM_CHANNELS; ch++) expLockFlags[ch] = lockOf(ch);
            expReadValid = pending.read;
            expReadData = pending.read ? modelRead(pending.addr[11:8], pending.addr[7:0]) : 0;
            for (ch = 0; ch < NUM_CHANNELS; ch++) begin
                expOutValid[ch] = errors[ch].valid;
                if (errors[ch].valid) begin
                    e = $signed(errors[ch].value);
                    if (ctrlReg[ch][0]) e = 0;
                    else if (ctrlReg[ch][1]) e = -e;
                    prop = scaled(e, leadLagReg[ch][31:24], leadLagReg[ch][20:16]);
                    step = scaled(e, leadLagReg[ch][15:8], leadLagReg[ch][4:0]);
                    if (ctrlReg[ch][3]) begin
                        accumModel[ch] = 0;
                    end else if (!ctrlReg[ch][2]) begin
                        sum = longint'(accumModel[ch]) + longint'(step);
                        lim = longint'({32'h0, limitReg[ch]});
                        if (sum > lim) sum = lim;
                        if (sum < -lim) sum = -lim;
                        accumModel[ch] = sum[31:0];
                    end
                    expLoopOut[ch] = loopDataReg[ch] + prop + accumModel[ch];
                    mag = (e < 0) ? -e : e;
                    if (mag < int'(lockDetReg[ch][23:16]))
                        lockCnt[ch] = (lockCnt[ch] == 16'hFFFF) ? lockCnt[ch] : lockCnt[ch] + 1;
                    else
                        lockCnt[ch] = 0;
                end
            end
            ch = pending.addr[11:8];
            if (ch < NUM_CHANNELS && pending.byteWrite != 0) begin
                case (pending.addr[7:0])
                    LF_CONTROL: ctrlReg[ch] = laneMerge(ctrlReg[ch], pending.dataIn,
                                                        pending.byteWrite, 32'h0000_000F);
                    LF_LEAD_LAG: leadLagReg[ch] = laneMerge(leadLagReg[ch], pending.dataIn,
                                                            pending.byteWrite, 32'hFF1F_FF1F);
                    LF_LIMIT: limitReg[ch] = laneMerge(limitReg[ch], pending.dataIn,
                                                       pending.byteWrite, 32'hFFFF_FFFF);
                    LF_LOOPDATA: loopDataReg[ch] = laneMerge(loopDataReg[ch], pending.dataIn,
                                                             pending.byteWrite, 32'hFFFF_FFFF);
                    LF_LOCKDETECTOR: lockDetReg[ch] = laneMerge(lockDetReg[ch], pending.dataIn,
                                                                pending.byteWrite, 32'h00FF_FFFF);
                    default: ;
                endcase
            end
            for (ch = 0; ch < NUM_CHANNELS; ch++) expLocked[ch] = lockOf(ch);
            pending = request;
        end
    end

    // Outputs settle after the rising edge, so compare half a cycle later
    always @(negedge clk) begin
        if (armed && !reset) begin
            compareWord("readValid", 0, 32'(readValid), 32'(expReadValid));
            if (expReadValid) compareWord("readData", 0, readData, expReadData);
            compareWord("lockFlags", 0, 32'(lockFlags), 32'(expLockFlags));
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                compareWord("outValid", ch, 32'(status[ch].outValid), 32'(expOutValid[ch]));
                if (expOutValid[ch]) compareWord("loopOut", ch, status[ch].loopOut, expLoopOut[ch]);
                compareWord("accum", ch, status[ch].accum, accumModel[ch]);
                compareWord("locked", ch, 32'(status[ch].locked), 32'(expLocked[ch]));
            end
        end
    end

endmodule

// File: tb/loopTb.sv
module loopTb;
    import loopPkg::*;

    localparam int STIM_CYCLES = 1500;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    logic        clk;
    logic        reset;
    busReq_t     request;
    errSample_t  [NUM_CHANNELS-1:0] errors;
    chanStatus_t [NUM_CHANNELS-1:0] status;
    logic [31:0] readData;
    logic        readValid;
    logic [NUM_CHANNELS-1:0] lockFlags;
    int          errorCount;
    int          checkCount;
    int          cycles;
    logic [31:0] lfsr;

    loopTop DUT (
        .clk(clk), .reset(reset), .request(request), .errors(errors), .status(status),
        .readData(readData), .readValid(readValid), .lockFlags(lockFlags)
    );

    loopChecker scoreboard (
        .clk(clk), .reset(reset), .request(request), .errors(errors), .status(status),
        .readData(readData), .readValid(readValid), .lockFlags(lockFlags),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        logic b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], b};
            r = {r[30:0], b};
        end
        return r;
    endfunction

    task automatic busWrite(int ch, logic [7:0] off, logic [31:0] data, logic [3:0] lanes);
        @(negedge clk);
        request = '{addr: {ch[3:0], off}, dataIn: data, byteWrite: lanes, read: 1'b0};
        @(negedge clk);
        request = '0;
    endtask

    task automatic busRead(int ch, logic [7:0] off);
        @(negedge clk);
        request = '{addr: {ch[3:0], off}, dataIn: 32'h0, byteWrite: 4'h0, read: 1'b1};
        @(negedge clk);
        request = '0;
        @(negedge clk);  // Data returns two cycles after the request
    endtask

    task automatic configure(int ch, logic [3:0] ctrl, logic [31:0] leadLag,
                             logic [31:0] limit, logic [31:0] loopData, logic [31:0] lockDet);
        busWrite(ch, LF_CONTROL, {28'h0, ctrl}, 4'hF);
        busWrite(ch, LF_LEAD_LAG, leadLag, 4'hF);
        busWrite(ch, LF_LIMIT, limit, 4'hF);
        busWrite(ch, LF_LOOPDATA, loopData, 4'hF);
        busWrite(ch, LF_LOCKDETECTOR, lockDet, 4'hF);
    endtask

    // Mode 1 alternates runs of small and large errors for the lock detector
    task automatic runSamples(int n, int mode);
        for (int c = 0; c < n; c++) begin
            @(negedge clk);
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                errors[ch].valid = (mode == 1) ? 1'b1 : randBits(2) != 0;
                if (mode == 1 && ((c / 12) % 2 == 0))
                    errors[ch].value = 16'($signed(randBits(5)) - 16);
                else
                    errors[ch].value = 16'(randBits(16));
            end
        end
        @(negedge clk);
        errors = '0;
    endtask

    initial begin
        lfsr = 32'h994d;
        cycles = 0;
        reset = 1'b1;
        request = '0;
        errors = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 150; i++) begin
            int ch;
            logic [7:0] off;
            ch = randBits(3);
            off = 8'(randBits(3)) << 2;  // Includes two unused offsets
            busWrite(ch, off, randBits(32), randBits(1) ? 4'hF : 4'(randBits(4)) | 4'h1);
            busRead(ch, off);
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            configure(ch, 4'h8, {8'(randBits(8)), 3'b0, 5'(randBits(5)), 16'h0},
                      0, randBits(32), 0);
        runSamples(60, 0);
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            configure(ch, 4'h0, {8'(randBits(8)), 8'h02, 8'(randBits(8)), 8'(randBits(3))},
                      randBits(14), randBits(32), 0);
        runSamples(80, 0);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) busRead(ch, LF_INTEGRATOR);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) busWrite(ch, LF_CONTROL, 32'h4, 4'h1);
        runSamples(30, 0);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) busRead(ch, LF_INTEGRATOR);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) busWrite(ch, LF_CONTROL, 32'h8, 4'h1);
        runSamples(10, 0);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) busWrite(ch, LF_CONTROL, ch % 2 + 1, 4'h1);
        runSamples(40, 0);
        for (int ch = 0; ch < NUM_CHANNELS; ch++)
            configure(ch, 4'(ch), {randBits(32)}, randBits(20), randBits(32),
                      {8'h0, 8'(randBits(5) + 4), 16'(randBits(4) + 1)});
        runSamples(200, 1);
        runSamples(100, 0);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) busRead(ch, LF_INTEGRATOR);
        repeat (4) @(negedge clk);
        @(posedge clk);  // Last compares are done by now
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: build.f
src/loopPkg.sv
src/busDecoder.sv
src/loopRegs.sv
src/loopFilter.sv
src/readMux.sv
src/loopTop.sv
tb/loopChecker.sv
tb/loopTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module loopTb -o loopSim
./obj_dir/loopSim > sim.log
cat sim.log
if grep -q "^No errors$" sim.log; then
    exit 0
fi
exit 1
